// ==== include/fmt_cfg.svh ====
`ifndef FMT_CFG_SVH
`define FMT_CFG_SVH

// storage slots of the calculator, one list entry each
`define FMT_LIST_DEPTH 10

// "Available Matrices:" plus its newline
`define FMT_HDR_MAX 20

// ascii codes shared by the generators and the sequencer
`define FMT_CHR_ZERO 8'h30
`define FMT_CHR_SPACE 8'h20
`define FMT_CHR_NL 8'h0a

`endif

// ==== src/fmt_pkg.sv ====
package fmt_pkg;

    typedef logic [7:0] char_t;   // one ascii character
    typedef logic [7:0] elem_t;   // unsigned matrix element
    typedef logic [2:0] dim_t;    // row or column count
    typedef logic [3:0] mat_id_t; // printed as one hex digit

    typedef enum logic [1:0] {
        MODE_MATRIX = 2'd0,
        MODE_LIST   = 2'd1,
        MODE_RESULT = 2'd2,
        MODE_RSVD   = 2'd3  // ignored at start
    } disp_mode_e;

    typedef enum logic {
        BODY_MATRIX = 1'b0,
        BODY_LIST   = 1'b1
    } body_sel_e;

    typedef enum logic [2:0] {
        IDLE   = 3'd0,
        HEADER = 3'd1,
        BODY   = 3'd2,
        TAIL   = 3'd3,  // closing newline after a matrix body
        DONE   = 3'd4
    } seq_state_e;

endpackage

// ==== src/header_gen.sv ====
`include "fmt_cfg.svh"

module header_gen (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start,
    input  fmt_pkg::disp_mode_e mode,
    input  fmt_pkg::mat_id_t    matrix_id,
    input  fmt_pkg::dim_t       dim_m,
    input  fmt_pkg::dim_t       dim_n,
    input  logic                char_take,
    output fmt_pkg::char_t      char_out,
    output logic                char_valid,
    output logic                char_last,
    output fmt_pkg::body_sel_e  body_sel
);
    import fmt_pkg::*;

    localparam int IDX_W = $clog2(`FMT_HDR_MAX);

    // fixed leading text of each header
    localparam logic [7*8-1:0]  MAT_TXT  = "Matrix ";
    localparam logic [8*8-1:0]  RES_TXT  = "Result (";
    localparam logic [19*8-1:0] LIST_TXT = "Available Matrices:";

    logic             active;
    logic [IDX_W-1:0] idx;
    disp_mode_e       mode_q;
    mat_id_t          id_q;
    dim_t             m_q;
    dim_t             n_q;
    logic [IDX_W-1:0] tail_idx;  // position inside "MxN):\n"
    char_t            tail_chr;
    char_t            id_chr;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active <= 1'b0;
            idx    <= '0;
        end else if (start) begin
            active <= 1'b1;
            idx    <= '0;
        end else if (char_take && active) begin
            if (char_last) active <= 1'b0;
            else           idx    <= idx + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            mode_q <= mode;
            id_q   <= matrix_id;
            m_q    <= dim_m;
            n_q    <= dim_n;
        end
    end

    // hex digit for the id, A to F above nine
    assign id_chr = (id_q < 4'd10) ? `FMT_CHR_ZERO + char_t'(id_q)
                                   : "A" + char_t'(id_q - 4'd10);

    assign tail_idx = (mode_q == MODE_RESULT) ? idx - IDX_W'(8) : idx - IDX_W'(10);

    always_comb begin
        case (tail_idx)
            IDX_W'(0): tail_chr = `FMT_CHR_ZERO + char_t'(m_q);
            IDX_W'(1): tail_chr = "x";
            IDX_W'(2): tail_chr = `FMT_CHR_ZERO + char_t'(n_q);
            IDX_W'(3): tail_chr = ")";
            IDX_W'(4): tail_chr = ":";
            default:   tail_chr = `FMT_CHR_NL;
        endcase
    end

    always_comb begin
        case (mode_q)
            MODE_LIST: begin
                if (idx < IDX_W'(19)) char_out = LIST_TXT[(18 - idx) * 8 +: 8];
                else                  char_out = `FMT_CHR_NL;
            end
            MODE_RESULT: begin
                if (idx < IDX_W'(8)) char_out = RES_TXT[(7 - idx) * 8 +: 8];
                else                 char_out = tail_chr;
            end
            default: begin
                if (idx < IDX_W'(7))       char_out = MAT_TXT[(6 - idx) * 8 +: 8];
                else if (idx == IDX_W'(7)) char_out = id_chr;
                else if (idx == IDX_W'(8)) char_out = `FMT_CHR_SPACE;
                else if (idx == IDX_W'(9)) char_out = "(";
                else                       char_out = tail_chr;
            end
        endcase
    end

    assign char_valid = active;
    assign char_last  = active && (char_out == `FMT_CHR_NL);  // only newline is the final one
    assign body_sel   = (mode_q == MODE_LIST) ? BODY_LIST : BODY_MATRIX;

endmodule

// ==== src/matrix_body_gen.sv ====
`include "fmt_cfg.svh"

module matrix_body_gen (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           start,
    input  fmt_pkg::dim_t  dim_m,
    input  fmt_pkg::dim_t  dim_n,
    input  fmt_pkg::elem_t matrix_data,
    input  logic           matrix_data_valid,
    input  logic           char_take,
    output logic           data_req,
    output fmt_pkg::char_t char_out,
    output logic           char_valid,
    output logic           char_last
);
    import fmt_pkg::*;

    // pos steps hundreds, tens, units, then the separator
    localparam logic [1:0] POS_HUND = 2'd0;
    localparam logic [1:0] POS_TENS = 2'd1;
    localparam logic [1:0] POS_UNIT = 2'd2;
    localparam logic [1:0] POS_SEP  = 2'd3;

    logic       active;
    logic       have_elem;
    elem_t      elem_q;
    logic [1:0] pos;
    dim_t       col;
    dim_t       n_q;
    logic [5:0] total_q;  // up to 7x7
    logic [5:0] cnt;
    logic       col_last;
    logic       elem_last;
    elem_t      hund;
    elem_t      tens;
    elem_t      units;

    assign data_req  = active && !have_elem;
    assign col_last  = (col == dim_t'(n_q - 1'b1));
    assign elem_last = (cnt == total_q - 6'd1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active    <= 1'b0;
            have_elem <= 1'b0;
            pos       <= POS_HUND;
            col       <= '0;
            n_q       <= '0;
            total_q   <= '0;
            cnt       <= '0;
        end else if (start) begin
            active    <= 1'b1;
            have_elem <= 1'b0;
            col       <= '0;
            cnt       <= '0;
            n_q       <= dim_n;
            total_q   <= 6'(dim_m) * 6'(dim_n);
        end else if (data_req && matrix_data_valid) begin
            have_elem <= 1'b1;
            // skip leading zeros, units always printed
            if (matrix_data >= 8'd100)     pos <= POS_HUND;
            else if (matrix_data >= 8'd10) pos <= POS_TENS;
            else                           pos <= POS_UNIT;
        end else if (char_take && char_valid) begin
            if (pos != POS_SEP) begin
                pos <= pos + 2'd1;
            end else begin
                have_elem <= 1'b0;  // fetch the next one
                cnt       <= cnt + 6'd1;
                col       <= col_last ? '0 : col + 1'b1;
                if (elem_last) active <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (data_req && matrix_data_valid) elem_q <= matrix_data;
    end

    assign hund  = elem_q / 8'd100;
    assign tens  = (elem_q / 8'd10) % 8'd10;
    assign units = elem_q % 8'd10;

    always_comb begin
        case (pos)
            POS_HUND: char_out = `FMT_CHR_ZERO + hund;
            POS_TENS: char_out = `FMT_CHR_ZERO + tens;
            POS_UNIT: char_out = `FMT_CHR_ZERO + units;
            default:  char_out = col_last ? `FMT_CHR_NL : `FMT_CHR_SPACE;
        endcase
    end

    assign char_valid = active && have_elem;
    assign char_last  = char_valid && (pos == POS_SEP) && elem_last;

endmodule

// ==== src/list_body_gen.sv ====
`include "fmt_cfg.svh"

module list_body_gen (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    start,
    input  fmt_pkg::dim_t [`FMT_LIST_DEPTH-1:0]     list_m,
    input  fmt_pkg::dim_t [`FMT_LIST_DEPTH-1:0]     list_n,
    input  logic          [`FMT_LIST_DEPTH-1:0]     list_valid,
    input  logic                                    char_take,
    output fmt_pkg::char_t                          char_out,
    output logic                                    char_valid,
    output logic                                    char_last
);
    import fmt_pkg::*;

    logic       active;
    logic [3:0] slot;
    logic [3:0] pos;   // character position inside one entry
    logic       at_nl;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active <= 1'b0;
            slot   <= '0;
            pos    <= '0;
        end else if (start) begin
            active <= 1'b1;
            slot   <= '0;
            pos    <= '0;
        end else if (char_take && active) begin
            if (at_nl) begin
                pos  <= '0;
                slot <= slot + 4'd1;
                if (char_last) active <= 1'b0;
            end else begin
                pos <= pos + 4'd1;
            end
        end
    end

    always_comb begin
        case (pos)
            4'd0: char_out = "[";
            4'd1: char_out = `FMT_CHR_ZERO + char_t'(slot);
            4'd2: char_out = "]";
            4'd3: char_out = `FMT_CHR_SPACE;
            default: begin
                if (list_valid[slot]) begin
                    case (pos)
                        4'd4:    char_out = `FMT_CHR_ZERO + char_t'(list_m[slot]);
                        4'd5:    char_out = "x";
                        4'd6:    char_out = `FMT_CHR_ZERO + char_t'(list_n[slot]);
                        default: char_out = `FMT_CHR_NL;
                    endcase
                end else begin
                    case (pos)
                        4'd4:    char_out = "E";
                        4'd5:    char_out = "m";
                        4'd6:    char_out = "p";
                        4'd7:    char_out = "t";
                        4'd8:    char_out = "y";
                        default: char_out = `FMT_CHR_NL;
                    endcase
                end
            end
        endcase
    end

    assign at_nl      = (char_out == `FMT_CHR_NL);
    assign char_valid = active;
    assign char_last  = active && at_nl && (slot == 4'(`FMT_LIST_DEPTH - 1));

endmodule

// ==== src/stream_sequencer.sv ====
`include "fmt_cfg.svh"

module stream_sequencer (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start_format,
    input  fmt_pkg::disp_mode_e display_mode,
    input  logic                tx_busy,
    input  fmt_pkg::body_sel_e  body_sel,
    input  fmt_pkg::char_t      hdr_char,
    input  logic                hdr_valid,
    input  logic                hdr_last,
    input  fmt_pkg::char_t      mat_char,
    input  logic                mat_valid,
    input  logic                mat_last,
    input  fmt_pkg::char_t      lst_char,
    input  logic                lst_valid,
    input  logic                lst_last,
    output logic                gen_start,
    output logic                mat_start,
    output logic                hdr_take,
    output logic                mat_take,
    output logic                lst_take,
    output fmt_pkg::char_t      tx_data,
    output logic                tx_valid,
    output logic                format_done
);
    import fmt_pkg::*;

    seq_state_e state;
    body_sel_e  body_q;
    char_t      cur_char;
    logic       cur_valid;
    logic       cur_last;
    logic       can_send;
    logic       take;
    logic       send;

    // busy was low last cycle and nothing was sent last cycle
    assign can_send = !tx_busy && !tx_valid;

    always_comb begin
        if (state == HEADER) begin
            cur_char  = hdr_char;
            cur_valid = hdr_valid;
            cur_last  = hdr_last;
        end else if (body_q == BODY_LIST) begin
            cur_char  = lst_char;
            cur_valid = lst_valid;
            cur_last  = lst_last;
        end else begin
            cur_char  = mat_char;
            cur_valid = mat_valid;
            cur_last  = mat_last;
        end
    end

    assign take     = (state == HEADER || state == BODY) && cur_valid && can_send;
    assign send     = take || (state == TAIL && can_send);
    assign hdr_take = take && (state == HEADER);
    assign mat_take = take && (state == BODY) && (body_q == BODY_MATRIX);
    assign lst_take = take && (state == BODY) && (body_q == BODY_LIST);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= IDLE;
            body_q      <= BODY_MATRIX;
            gen_start   <= 1'b0;
            mat_start   <= 1'b0;
            tx_valid    <= 1'b0;
            format_done <= 1'b0;
        end else begin
            gen_start   <= 1'b0;
            mat_start   <= 1'b0;
            tx_valid    <= send;
            format_done <= 1'b0;
            case (state)
                IDLE: begin
                    if (start_format && display_mode != MODE_RSVD) begin
                        gen_start <= 1'b1;
                        // first element is fetched while the header goes out
                        mat_start <= (display_mode != MODE_LIST);
                        state     <= HEADER;
                    end
                end
                HEADER: begin
                    if (take && cur_last) begin
                        body_q <= body_sel;
                        state  <= BODY;
                    end
                end
                BODY: begin
                    if (take && cur_last) state <= (body_q == BODY_MATRIX) ? TAIL : DONE;
                end
                TAIL: begin
                    if (can_send) state <= DONE;
                end
                DONE: begin
                    format_done <= 1'b1;  // cycle after the last tx_valid
                    state       <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (send) tx_data <= (state == TAIL) ? `FMT_CHR_NL : cur_char;
    end

endmodule

// ==== src/display_formatter.sv ====
`include "fmt_cfg.svh"

module display_formatter (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                start_format,
    input  fmt_pkg::disp_mode_e                 display_mode,
    input  fmt_pkg::mat_id_t                    matrix_id,
    input  fmt_pkg::dim_t                       dim_m,
    input  fmt_pkg::dim_t                       dim_n,
    input  fmt_pkg::elem_t                      matrix_data,
    input  logic                                matrix_data_valid,
    input  fmt_pkg::dim_t [`FMT_LIST_DEPTH-1:0] list_m,
    input  fmt_pkg::dim_t [`FMT_LIST_DEPTH-1:0] list_n,
    input  logic          [`FMT_LIST_DEPTH-1:0] list_valid,
    input  logic                                tx_busy,
    output fmt_pkg::char_t                      tx_data,
    output logic                                tx_valid,
    output logic                                data_req,
    output logic                                format_done
);
    import fmt_pkg::*;

    logic      gen_start;
    logic      mat_start;
    body_sel_e body_sel;
    char_t     hdr_char;
    char_t     mat_char;
    char_t     lst_char;
    logic      hdr_valid, hdr_last, hdr_take;
    logic      mat_valid, mat_last, mat_take;
    logic      lst_valid, lst_last, lst_take;

    stream_sequencer u_seq (
        .clk, .rst_n, .start_format, .display_mode, .tx_busy, .body_sel,
        .hdr_char, .hdr_valid, .hdr_last,
        .mat_char, .mat_valid, .mat_last,
        .lst_char, .lst_valid, .lst_last,
        .gen_start, .mat_start, .hdr_take, .mat_take, .lst_take,
        .tx_data, .tx_valid, .format_done
    );

    header_gen u_hdr (
        .clk, .rst_n, .start(gen_start), .mode(display_mode), .matrix_id, .dim_m, .dim_n,
        .char_take(hdr_take), .char_out(hdr_char), .char_valid(hdr_valid),
        .char_last(hdr_last), .body_sel
    );

    matrix_body_gen u_mat (
        .clk, .rst_n, .start(mat_start), .dim_m, .dim_n, .matrix_data, .matrix_data_valid,
        .char_take(mat_take), .data_req, .char_out(mat_char), .char_valid(mat_valid),
        .char_last(mat_last)
    );

    list_body_gen u_lst (
        .clk, .rst_n, .start(gen_start), .list_m, .list_n, .list_valid,
        .char_take(lst_take), .char_out(lst_char), .char_valid(lst_valid),
        .char_last(lst_last)
    );

endmodule

// ==== testbench/tb_clock_gen.sv ====
module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // 8 unit period
    end

    initial begin
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        #1 rst_n = 1'b1;  // released together with the other inputs
    end

endmodule

// ==== testbench/tb_display_formatter.sv ====
`include "fmt_cfg.svh"

module tb_display_formatter;
    import fmt_pkg::*;

    localparam int VEC_DEPTH  = 512;
    localparam int HDR_BYTES  = 29;    // fixed fields in front of the elements
    localparam int WAIT_LIMIT = 4000;  // cycles allowed for one case

    logic                       clk;
    logic                       rst_n;
    logic                       start_format;
    disp_mode_e                 display_mode;
    mat_id_t                    matrix_id;
    dim_t                       dim_m;
    dim_t                       dim_n;
    elem_t                      matrix_data;
    logic                       matrix_data_valid;
    dim_t [`FMT_LIST_DEPTH-1:0] list_m;
    dim_t [`FMT_LIST_DEPTH-1:0] list_n;
    logic [`FMT_LIST_DEPTH-1:0] list_valid;
    logic                       tx_busy;
    char_t                      tx_data;
    logic                       tx_valid;
    logic                       data_req;
    logic                       format_done;

    logic [7:0] vec [0:VEC_DEPTH-1];
    char_t      got [$];  // characters seen on the uart side
    int         errors;
    int         timeouts;
    int         done_cnt;
    int         answered;
    int         elem_ptr;
    logic       busy_on;
    logic       list_case;
    logic       prev_valid;
    logic       prev_busy;

    tb_clock_gen clock_gen (.clk, .rst_n);

    display_formatter UUT (.*);

    // uart stays busy a random number of cycles after each character
    task automatic drive_uart_busy();
        int hold;
        forever begin
            @(negedge clk);
            if (tx_valid && busy_on) begin
                hold = $urandom_range(5, 0);
                @(posedge clk);
                #1 tx_busy = (hold != 0);
                if (hold != 0) begin
                    repeat (hold) @(posedge clk);
                    #1 tx_busy = 1'b0;
                end
            end
        end
    endtask

    task automatic supply_elements();
        int gap;
        forever begin
            @(negedge clk);
            if (data_req) begin
                gap = $urandom_range(3, 1);
                repeat (gap) @(posedge clk);
                #1;
                matrix_data       = vec[elem_ptr];
                matrix_data_valid = 1'b1;
                elem_ptr++;
                answered++;
                @(posedge clk);
                #1 matrix_data_valid = 1'b0;
            end
        end
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        if (!rst_n) begin
            assert (!tx_valid && !data_req && !format_done) else begin
                errors++;
                $display("ERR %0t: outputs active during reset", $time);
            end
        end else begin
            assert (!(tx_valid && (prev_valid || prev_busy))) else begin
                errors++;
                $display("ERR %0t: tx_valid right after a send or a busy cycle", $time);
            end
            if (list_case) begin
                assert (!data_req) else begin
                    errors++;
                    $display("ERR %0t: data_req raised in list mode", $time);
                end
            end
            if (tx_valid) got.push_back(tx_data);
            if (format_done) begin
                done_cnt++;
                assert (prev_valid) else begin
                    errors++;
                    $display("ERR %0t: format_done without tx_valid the cycle before", $time);
                end
            end
        end
        prev_valid = tx_valid;
        prev_busy  = tx_busy;
    end

    task automatic run_case(input int base, output int next);
        int nel;
        int nexp;
        int w;
        int i;
        nel  = vec[base + 7];
        nexp = vec[base + 8];
        @(posedge clk);
        #1;
        display_mode = disp_mode_e'(vec[base][1:0]);
        matrix_id    = vec[base + 1][3:0];
        dim_m        = vec[base + 2][2:0];
        dim_n        = vec[base + 3][2:0];
        busy_on      = vec[base + 4][0];
        list_valid   = {vec[base + 5][1:0], vec[base + 6]};
        for (i = 0; i < `FMT_LIST_DEPTH; i++) begin
            list_m[i] = vec[base + 9 + i][2:0];
            list_n[i] = vec[base + 19 + i][2:0];
        end
        elem_ptr  = base + HDR_BYTES;
        answered  = 0;
        done_cnt  = 0;
        got.delete();
        list_case = (display_mode == MODE_LIST);
        start_format = 1'b1;
        @(posedge clk);
        #1 start_format = 1'b0;
        if (display_mode == MODE_RSVD) begin
            repeat (50) @(posedge clk);  // start must stay ignored
            assert (got.size() == 0 && done_cnt == 0) else begin
                errors++;
                $display("ERR %0t: reserved mode produced output", $time);
            end
        end else begin
            w = 0;
            while (done_cnt == 0 && w < WAIT_LIMIT) begin
                @(posedge clk);
                w++;
            end
            if (done_cnt == 0) begin
                timeouts++;
                $display("Timeout: no format_done for the case at vector byte %0d", base);
            end else begin
                repeat (4) @(posedge clk);  // room for a stray second pulse
                assert (done_cnt == 1) else begin
                    errors++;
                    $display("ERR %0t: %0d format_done pulses", $time, done_cnt);
                end
                assert (answered == nel) else begin
                    errors++;
                    $display("ERR %0t: %0d elements fetched, %0d expected", $time, answered, nel);
                end
                assert (got.size() == nexp) else begin
                    errors++;
                    $display("ERR %0t: %0d chars sent, %0d expected", $time, got.size(), nexp);
                end
                for (i = 0; i < nexp && i < got.size(); i++) begin
                    assert (got[i] == vec[base + HDR_BYTES + nel + i]) else begin
                        errors++;
                        $display("ERR %0t: char %0d is %h, expected %h", $time, i, got[i],
                                 vec[base + HDR_BYTES + nel + i]);
                    end
                end
            end
        end
        list_case = 1'b0;
        next = base + HDR_BYTES + nel + nexp;
    endtask

    initial begin : main_flow
        int p;
        int nxt;
        int k;
        void'($urandom(37));
        start_format      = 1'b0;
        display_mode      = MODE_MATRIX;
        matrix_id         = '0;
        dim_m             = '0;
        dim_n             = '0;
        matrix_data       = '0;
        matrix_data_valid = 1'b0;
        list_m            = '0;
        list_n            = '0;
        list_valid        = '0;
        tx_busy           = 1'b0;
        busy_on           = 1'b0;
        list_case         = 1'b0;
        prev_valid        = 1'b0;
        prev_busy         = 1'b0;
        errors            = 0;
        timeouts          = 0;
        done_cnt          = 0;
        answered          = 0;
        elem_ptr          = 0;
        $readmemh("testbench/display_vectors.txt", vec);
        fork
            drive_uart_busy();
            supply_elements();
        join_none

        k = 0;
        while (rst_n !== 1'b1 && k < 100) begin
            @(posedge clk);
            k++;
        end
        if (rst_n !== 1'b1) begin
            timeouts++;
            $display("Timeout: reset was never released");
        end
        for (k = 0; k < 3; k++) begin
            @(negedge clk);
            assert (!tx_valid && !data_req && !format_done) else begin
                errors++;
                $display("ERR %0t: outputs active right after reset", $time);
            end
        end
        if ($isunknown(vec[0])) begin
            errors++;
            $display("The vector file testbench/display_vectors.txt could not be read");
        end

        p = 0;
        while (timeouts == 0 && p < VEC_DEPTH - HDR_BYTES && vec[p] !== 8'hff
               && !$isunknown(vec[p])) begin
            run_case(p, nxt);
            p = nxt;
        end

        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== testbench/display_vectors.txt ====
// mode id m n busy valid_hi valid_lo n_elem n_exp, list_m[0..9], list_n[0..9]
// then n_elem elements and n_exp expected ascii bytes; a mode of ff ends the file
// matrix 3, 2x3, uart never busy
00 03 02 03 00 00 00 06 22 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
00 07 2a ff 64 09
4d 61 74 72 69 78 20 33 20 28 32 78 33 29 3a 0a 30 20 37 20 34 32 0a
32 35 35 20 31 30 30 20 39 0a 0a
// result, 2x2, random busy
02 00 02 02 01 00 00 04 1b 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
01 0a 63 c8
52 65 73 75 6c 74 20 28 32 78 32 29 3a 0a 31 20 31 30 0a 39 39 20 32 30 30 0a 0a
// list, slots 0 2 5 9 valid, random busy
01 00 00 00 01 02 25 00 70 02 03 01 00 00 07 00 00 00 04 03 03 01 00 00 07 00 00 00 02
41 76 61 69 6c 61 62 6c 65 20 4d 61 74 72 69 63 65 73 3a 0a
5b 30 5d 20 32 78 33 0a 5b 31 5d 20 45 6d 70 74 79 0a 5b 32 5d 20 31 78 31 0a
5b 33 5d 20 45 6d 70 74 79 0a 5b 34 5d 20 45 6d 70 74 79 0a
5b 35 5d 20 37 78 37 0a 5b 36 5d 20 45 6d 70 74 79 0a 5b 37 5d 20 45 6d 70 74 79 0a
5b 38 5d 20 45 6d 70 74 79 0a 5b 39 5d 20 34 78 32 0a
// reserved mode, nothing may be sent
03 00 02 02 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
// matrix b, 1x1, random busy
00 0b 01 01 01 00 00 01 13 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
05
4d 61 74 72 69 78 20 42 20 28 31 78 31 29 3a 0a 35 0a 0a
ff

// ==== project.f ====
+incdir+include
src/fmt_pkg.sv
src/header_gen.sv
src/matrix_body_gen.sv
src/list_body_gen.sv
src/stream_sequencer.sv
src/display_formatter.sv
testbench/tb_clock_gen.sv
testbench/tb_display_formatter.sv

// ==== Bender.yml ====
package:
  name: display_formatter

sources:
  - include_dirs:
      - include
    files:
      - src/fmt_pkg.sv
      - src/header_gen.sv
      - src/matrix_body_gen.sv
      - src/list_body_gen.sv
      - src/stream_sequencer.sv
      - src/display_formatter.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/tb_clock_gen.sv
      - testbench/tb_display_formatter.sv
